/* src/tcp_ctrl_params.svh */
`ifndef TCP_CTRL_PARAMS_SVH
`define TCP_CTRL_PARAMS_SVH

// ----------------------------------------
// Field widths
// ----------------------------------------
`define TCP_PORT_W      16
`define TCP_NUM_W       32
`define TCP_LEN_W       16

// Our side of the single connection (63256)
`define TCP_LOCAL_PORT  16'hF718

// No options, so always five 32-bit words
`define TCP_HEAD_LEN    4'd5

// ----------------------------------------
// Reply flag codes, URG ACK PSH RST SYN FIN
// ----------------------------------------
`define TCP_FLG_SYNACK  6'h12
`define TCP_FLG_RSTACK  6'h14
`define TCP_FLG_RST     6'h04
`define TCP_FLG_ACK     6'h10
`define TCP_FLG_PSHACK  6'h18
`define TCP_FLG_FINACK  6'h11

// Pacing limits
`define TCP_MAX_UNACKED 16
`define TCP_WINDOW_MIN  25000

`define TCP_FIFO_DEPTH  4

`endif

/* src/tcp_ctrl_pkg.sv */
`default_nettype none

`include "tcp_ctrl_params.svh"

package tcp_ctrl_pkg;

	// One-hot connection state
	typedef enum logic [5:0] {
		ST_LISTEN      = 6'b00_0001,
		ST_SYN_RCVD    = 6'b00_0010,
		ST_ESTABLISHED = 6'b00_0100,
		ST_CLOSE_WAIT  = 6'b00_1000,
		ST_LAST_ACK    = 6'b01_0000,
		ST_CLOSED      = 6'b10_0000
	} tcp_state_e;

	// Flag bits in header order
	typedef struct packed {
		logic urg;
		logic ack;
		logic psh;
		logic rst;
		logic syn;
		logic fin;
	} tcp_flag_bits_t;

	// Whole code for replies, single bits for decoding
	typedef union packed {
		logic [5:0]     code;
		tcp_flag_bits_t bits;
	} tcp_flags_u;

	// Decoded received segment
	typedef struct packed {
		logic [`TCP_PORT_W-1:0] src_port;
		tcp_flags_u             flags;
		logic [`TCP_NUM_W-1:0]  seq_num;
		logic [`TCP_NUM_W-1:0]  ack_num;
		logic [`TCP_LEN_W-1:0]  data_len;
		logic [`TCP_LEN_W-1:0]  window;
	} tcp_seg_t;

	// Header fields handed to the transmit encoder
	typedef struct packed {
		logic [`TCP_PORT_W-1:0] dst_port;
		tcp_flags_u             flags;
		logic [`TCP_NUM_W-1:0]  seq_num;
		logic [`TCP_NUM_W-1:0]  ack_num;
		logic [3:0]             head_len;
		logic [`TCP_LEN_W-1:0]  data_len;
	} tcp_hdr_t;

endpackage

`default_nettype wire

/* src/tcp_seg_sampler.sv */
`timescale 1ns/1ps
`default_nettype none

module tcp_seg_sampler (
	input  wire                         clk,
	input  wire                         rst_n,

	// Receive parser side
	input  wire                         seg_valid_i,
	input  wire tcp_ctrl_pkg::tcp_seg_t seg_i,
	output logic                        seg_rd_o,

	// Event FIFO side
	input  wire                         fifo_full_i,
	output logic                        push_o,
	output tcp_ctrl_pkg::tcp_seg_t      push_seg_o
);

	logic rd_req;

	// ----------------------------------------
	// Read pulse
	// ----------------------------------------
	// The parser holds its segment until it sees the pulse, so a read
	// is never issued two cycles in a row
	assign rd_req = seg_valid_i && !fifo_full_i && !seg_rd_o;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			seg_rd_o <= 1'b0;
		end
		else
		begin
			seg_rd_o <= rd_req;
		end
	end

	// ----------------------------------------
	// Push into the FIFO
	// ----------------------------------------
	// Segment is still held by the parser during the read cycle
	assign push_o     = seg_rd_o;
	assign push_seg_o = seg_i;

endmodule

`default_nettype wire

/* src/tcp_event_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tcp_ctrl_params.svh"

module tcp_event_fifo (
	input  wire                         clk,
	input  wire                         rst_n,
	input  wire                         push_i,
	input  wire tcp_ctrl_pkg::tcp_seg_t push_seg_i,
	input  wire                         pop_i,
	output logic                        full_o,
	output logic                        valid_o,
	output tcp_ctrl_pkg::tcp_seg_t      head_o
);

	import tcp_ctrl_pkg::*;

	localparam int DEPTH = `TCP_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	tcp_seg_t         mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic             do_push;
	logic             do_pop;

	// Wrap at DEPTH, also for depths that are not a power of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		logic [PTR_W-1:0] nxt;
		nxt = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
		return nxt;
	endfunction

	assign do_push = push_i && !full_o;
	assign do_pop  = pop_i && valid_o;

	// Storage
	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr] <= push_seg_i;
	end

	// ----------------------------------------
	// Pointers and fill count
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Head is shown combinationally
	assign full_o  = (count == DEPTH);
	assign valid_o = (count != '0);
	assign head_o  = mem[rd_ptr];

endmodule

`default_nettype wire

/* src/tcp_conn_engine.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tcp_ctrl_params.svh"

module tcp_conn_engine (
	input  wire                         clk,
	input  wire                         rst_n,
	input  wire                         ev_valid_i,
	input  wire tcp_ctrl_pkg::tcp_seg_t ev_i,
	input  wire                         trnsmt_busy_i,
	input  wire [`TCP_LEN_W-1:0]        data_len_i,
	input  wire                         wdat_start_i,
	input  wire                         data_done_i,
	output logic                        ev_pop_o,
	output logic                        ctrl_cmd_start_o,
	output tcp_ctrl_pkg::tcp_hdr_t      hdr_o,
	output logic                        est_o,
	output logic                        window_open_o,
	output logic                        ack_seen_o,
	output logic                        ctrl_pending_o,
	output logic                        state_listen_o,
	output logic                        state_estblsh_o
);

	import tcp_ctrl_pkg::*;

	// Initial send sequence number, kept at zero
	localparam logic [`TCP_NUM_W-1:0] ISS = '0;

	tcp_state_e             state;
	tcp_state_e             state_nxt;
	logic                   reply;
	logic                   syn_rcv;
	logic                   ack_rcv;
	logic                   fin_rcv;
	logic                   rst_rcv;
	logic                   in_order;
	logic                   port_match;
	logic [`TCP_PORT_W-1:0] remote_port;
	tcp_flags_u             flags_r;
	logic [`TCP_NUM_W-1:0]  seq_r;
	logic [`TCP_NUM_W-1:0]  ack_r;
	logic [`TCP_NUM_W-1:0]  ack_next;
	logic [`TCP_NUM_W-1:0]  window_r;
	logic [`TCP_LEN_W-1:0]  data_len_r;

	// Pop only while the transmit side is quiet
	assign ev_pop_o = ev_valid_i && !ctrl_cmd_start_o && (state != ST_CLOSE_WAIT)
		&& !wdat_start_i && !trnsmt_busy_i && !data_done_i;

	assign syn_rcv    = ev_pop_o && ev_i.flags.bits.syn;
	assign ack_rcv    = ev_pop_o && ev_i.flags.bits.ack;
	assign fin_rcv    = ev_pop_o && ev_i.flags.bits.fin;
	assign rst_rcv    = ev_pop_o && ev_i.flags.bits.rst;
	assign in_order   = (ev_i.seq_num == ack_next);
	assign port_match = (ev_i.src_port == remote_port);

	// ----------------------------------------
	// Next state and reply decision
	// ----------------------------------------
	always_comb
	begin
		state_nxt = state;
		reply     = 1'b0;
		case (state)
			ST_LISTEN:
			begin
				// RST is ignored while listening
				if (!rst_rcv && (syn_rcv || ack_rcv))
					reply = 1'b1;
				if (!rst_rcv && syn_rcv && !ack_rcv)
					state_nxt = ST_SYN_RCVD;
			end
			ST_SYN_RCVD:
			begin
				if (rst_rcv)
					state_nxt = ST_LISTEN;
				else if (syn_rcv)
					state_nxt = ST_CLOSED;
				else if (ack_rcv)
					state_nxt = ST_ESTABLISHED;
			end
			ST_ESTABLISHED:
			begin
				if (rst_rcv)
				begin
					if (port_match)
						state_nxt = ST_CLOSED;
				end
				else if (fin_rcv)
					state_nxt = ST_CLOSE_WAIT;
				else if (ack_rcv && (ev_i.data_len != '0))
					reply = 1'b1;
			end
			ST_CLOSE_WAIT:
			begin
				// FIN+ACK goes out one cycle after the FIN was taken
				state_nxt = ST_LAST_ACK;
				reply     = 1'b1;
			end
			ST_LAST_ACK:
			begin
				if (rst_rcv || ack_rcv)
					state_nxt = ST_CLOSED;
			end
			ST_CLOSED:
			begin
				state_nxt = ST_LISTEN;
				if (ev_pop_o && !rst_rcv)
					reply = 1'b1;
			end
			default:
				state_nxt = ST_LISTEN;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state            <= ST_LISTEN;
			ctrl_cmd_start_o <= 1'b0;
		end
		else
		begin
			state            <= state_nxt;
			ctrl_cmd_start_o <= reply;
		end
	end

	// ----------------------------------------
	// Header fields for the encoder
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			flags_r    <= '0;
			seq_r      <= '0;
			ack_r      <= '0;
			data_len_r <= '0;
		end
		else if (wdat_start_i)
		begin
			flags_r.code <= `TCP_FLG_PSHACK;
			data_len_r   <= data_len_i;
		end
		else if (data_done_i)
			seq_r <= seq_r + data_len_i;
		else if (reply)
		begin
			data_len_r <= '0;
			case (state)
				ST_LISTEN:
				begin
					if (syn_rcv && !ack_rcv)
					begin
						flags_r.code <= `TCP_FLG_SYNACK;
						seq_r        <= ISS;
						ack_r        <= ev_i.seq_num + 1'b1;
					end
					else
					begin
						flags_r.code <= `TCP_FLG_RSTACK;
						seq_r        <= ev_i.ack_num;
						ack_r        <= ev_i.seq_num;
					end
				end
				ST_ESTABLISHED:
				begin
					// Out of order data gets the previous ack number again
					flags_r.code <= `TCP_FLG_ACK;
					if (in_order)
						ack_r <= ev_i.seq_num + ev_i.data_len;
				end
				ST_CLOSE_WAIT:
					flags_r.code <= `TCP_FLG_FINACK;
				ST_CLOSED:
				begin
					if (ack_rcv)
					begin
						flags_r.code <= `TCP_FLG_RSTACK;
						seq_r        <= ev_i.ack_num;
					end
					else
					begin
						flags_r.code <= `TCP_FLG_RST;
						ack_r        <= ev_i.seq_num + ev_i.data_len;
					end
				end
				default:
					flags_r <= flags_r;
			endcase
		end
		else if (ack_rcv && (state == ST_SYN_RCVD))
			seq_r <= seq_r + 1'b1;
		else if (fin_rcv && (state == ST_ESTABLISHED))
			ack_r <= ev_i.seq_num + 1'b1;
	end

	// ----------------------------------------
	// Connection bookkeeping
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			remote_port <= '0;
			ack_next    <= '0;
			window_r    <= '0;
		end
		else
		begin
			if (syn_rcv && !ack_rcv && !rst_rcv && (state == ST_LISTEN))
				remote_port <= ev_i.src_port;

			if (ack_rcv && (state == ST_SYN_RCVD))
				ack_next <= ev_i.seq_num + ev_i.data_len;
			else if (ack_rcv && (state == ST_ESTABLISHED) && in_order)
				ack_next <= ev_i.seq_num + ev_i.data_len;

			// Usable window, right edge minus what we have sent
			if (ev_pop_o && (state == ST_SYN_RCVD))
				window_r <= {{(`TCP_NUM_W - `TCP_LEN_W){1'b0}}, ev_i.window};
			else if (ev_pop_o && (state == ST_ESTABLISHED))
				window_r <= ev_i.ack_num + ev_i.window - seq_r;
		end
	end

	always_comb
	begin
		hdr_o.dst_port = remote_port;
		hdr_o.flags    = flags_r;
		hdr_o.seq_num  = seq_r;
		hdr_o.ack_num  = ack_r;
		hdr_o.head_len = `TCP_HEAD_LEN;
		hdr_o.data_len = data_len_r;
	end

	// Status towards the pacer and the outside
	assign est_o           = (state == ST_ESTABLISHED);
	assign window_open_o   = (window_r > `TCP_WINDOW_MIN);
	assign ack_seen_o      = ack_rcv && (state == ST_ESTABLISHED);
	assign ctrl_pending_o  = ev_pop_o || ctrl_cmd_start_o || (state == ST_CLOSE_WAIT);
	assign state_listen_o  = (state == ST_LISTEN);
	assign state_estblsh_o = (state == ST_ESTABLISHED);

endmodule

`default_nettype wire

/* src/tcp_data_pacer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tcp_ctrl_params.svh"

module tcp_data_pacer (
	input  wire  clk,
	input  wire  rst_n,

	// From the connection engine
	input  wire  est_i,
	input  wire  window_open_i,
	input  wire  ctrl_pending_i,
	input  wire  ack_seen_i,
	input  wire  ev_valid_i,

	// Data source and encoder
	input  wire  trnsmt_busy_i,
	input  wire  data_rdy_i,
	input  wire  tcp_wdat_stop_i,
	output logic wdat_start_o,
	output logic data_done_o
);

	localparam int MAX_UNACKED = `TCP_MAX_UNACKED;
	localparam int CNT_W       = $clog2(MAX_UNACKED + 1);

	logic [CNT_W-1:0] unacked_cnt;
	logic             lock;
	logic             start_ok;

	// Received events and control replies win over data
	assign start_ok = est_i && data_rdy_i && window_open_i
		&& (unacked_cnt < MAX_UNACKED) && !lock && !trnsmt_busy_i
		&& !ev_valid_i && !ctrl_pending_i && !data_done_o;

	// ----------------------------------------
	// Start pulse and packet lock
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wdat_start_o <= 1'b0;
			lock         <= 1'b0;
			data_done_o  <= 1'b0;
		end
		else
		begin
			wdat_start_o <= start_ok;
			data_done_o  <= lock && tcp_wdat_stop_i;
			if (!est_i)
				lock <= 1'b0;
			else if (lock && tcp_wdat_stop_i)
				lock <= 1'b0;
			else if (start_ok)
				lock <= 1'b1;
		end
	end

	// Packets sent since the last ACK
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			unacked_cnt <= '0;
		else if (!est_i || ack_seen_i)
			unacked_cnt <= '0;
		else if (start_ok)
			unacked_cnt <= unacked_cnt + 1'b1;
	end

endmodule

`default_nettype wire

/* src/tcp_controller_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tcp_ctrl_params.svh"

module tcp_controller_top (
	input  wire                         clk,
	input  wire                         rst_n,

	// Receive parser
	input  wire                         seg_valid_i,
	input  wire tcp_ctrl_pkg::tcp_seg_t seg_i,
	output wire                         seg_rd_o,

	// Data source
	input  wire                         data_rdy_i,
	input  wire [`TCP_LEN_W-1:0]        data_len_i,

	// Transmit encoder
	input  wire                         trnsmt_busy_i,
	input  wire                         tcp_wdat_stop_i,
	output wire                         ctrl_cmd_start_o,
	output wire                         tcp_wdat_start_o,
	output wire [`TCP_PORT_W-1:0]       tcp_source_port_o,
	output wire tcp_ctrl_pkg::tcp_hdr_t hdr_o,

	// Connection status
	output wire                         state_listen_o,
	output wire                         state_estblsh_o
);

	import tcp_ctrl_pkg::*;

	tcp_seg_t push_seg;
	tcp_seg_t head_seg;
	logic     push;
	logic     fifo_full;
	logic     ev_valid;
	logic     ev_pop;
	logic     est;
	logic     window_open;
	logic     ack_seen;
	logic     ctrl_pending;
	logic     data_done;

	assign tcp_source_port_o = `TCP_LOCAL_PORT;

	// ----------------------------------------
	// Receive path
	// ----------------------------------------
	tcp_seg_sampler i_sampler (
		.clk         (clk),
		.rst_n       (rst_n),
		.seg_valid_i (seg_valid_i),
		.seg_i       (seg_i),
		.seg_rd_o    (seg_rd_o),
		.fifo_full_i (fifo_full),
		.push_o      (push),
		.push_seg_o  (push_seg)
	);

	tcp_event_fifo i_fifo (
		.clk        (clk),
		.rst_n      (rst_n),
		.push_i     (push),
		.push_seg_i (push_seg),
		.pop_i      (ev_pop),
		.full_o     (fifo_full),
		.valid_o    (ev_valid),
		.head_o     (head_seg)
	);

	// ----------------------------------------
	// Connection engine and data pacing
	// ----------------------------------------
	tcp_conn_engine i_engine (
		.clk              (clk),
		.rst_n            (rst_n),
		.ev_valid_i       (ev_valid),
		.ev_i             (head_seg),
		.trnsmt_busy_i    (trnsmt_busy_i),
		.data_len_i       (data_len_i),
		.wdat_start_i     (tcp_wdat_start_o),
		.data_done_i      (data_done),
		.ev_pop_o         (ev_pop),
		.ctrl_cmd_start_o (ctrl_cmd_start_o),
		.hdr_o            (hdr_o),
		.est_o            (est),
		.window_open_o    (window_open),
		.ack_seen_o       (ack_seen),
		.ctrl_pending_o   (ctrl_pending),
		.state_listen_o   (state_listen_o),
		.state_estblsh_o  (state_estblsh_o)
	);

	tcp_data_pacer i_pacer (
		.clk             (clk),
		.rst_n           (rst_n),
		.est_i           (est),
		.window_open_i   (window_open),
		.ctrl_pending_i  (ctrl_pending),
		.ack_seen_i      (ack_seen),
		.ev_valid_i      (ev_valid),
		.trnsmt_busy_i   (trnsmt_busy_i),
		.data_rdy_i      (data_rdy_i),
		.tcp_wdat_stop_i (tcp_wdat_stop_i),
		.wdat_start_o    (tcp_wdat_start_o),
		.data_done_o     (data_done)
	);

endmodule

`default_nettype wire

/* sim/tcp_controller_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tcp_ctrl_params.svh"

module tcp_controller_tb;

	import tcp_ctrl_pkg::*;

	localparam int TIMEOUT = 200;

	logic                   clk;
	logic                   rst_n;
	logic                   seg_valid;
	tcp_seg_t               seg;
	logic                   seg_rd;
	logic                   data_rdy;
	logic [`TCP_LEN_W-1:0]  data_len;
	logic                   trnsmt_busy;
	logic                   wdat_stop;
	logic                   ctrl_start;
	logic                   wdat_start;
	logic [`TCP_PORT_W-1:0] src_port;
	tcp_hdr_t               hdr;
	logic                   st_listen;
	logic                   st_estblsh;

	// Fields of the current record
	logic [31:0] op, port, flg, seq, ack, len, win, busy;
	logic [31:0] eflg, eseq, eack, elen, eport, estate;
	logic [31:0] rng;
	int          errors;
	int          checks;
	int          tests;

	tcp_controller_top i_dut (
		.clk               (clk),
		.rst_n             (rst_n),
		.seg_valid_i       (seg_valid),
		.seg_i             (seg),
		.seg_rd_o          (seg_rd),
		.data_rdy_i        (data_rdy),
		.data_len_i        (data_len),
		.trnsmt_busy_i     (trnsmt_busy),
		.tcp_wdat_stop_i   (wdat_stop),
		.ctrl_cmd_start_o  (ctrl_start),
		.tcp_wdat_start_o  (wdat_start),
		.tcp_source_port_o (src_port),
		.hdr_o             (hdr),
		.state_listen_o    (st_listen),
		.state_estblsh_o   (st_estblsh)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act)
		begin
			errors++;
			$display("ERROR at %0t ns: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic fail(input string what);
		errors++;
		$display("At %0t ns: %s", $time, what);
	endtask

	// Parser holds the segment until the read pulse
	task automatic send_seg();
		int n;
		@(negedge clk);
		seg.src_port   = port[15:0];
		seg.flags.code = flg[5:0];
		seg.seq_num    = seq;
		seg.ack_num    = ack;
		seg.data_len   = len[15:0];
		seg.window     = win[15:0];
		seg_valid      = 1'b1;
		n = 0;
		while (!seg_rd && n < TIMEOUT)
		begin
			@(negedge clk);
			n++;
		end
		if (!seg_rd)
			fail("segment was never read by the controller");
		seg_valid = 1'b0;
	endtask

	task automatic wait_reply(output bit ok);
		int n;
		n = 0;
		while (!ctrl_start && n < TIMEOUT)
		begin
			@(negedge clk);
			n++;
		end
		ok = ctrl_start;
		if (!ok)
			fail("no control reply arrived");
	endtask

	task automatic check_quiet(input int cycles);
		repeat (cycles)
		begin
			@(negedge clk);
			if (ctrl_start)
				fail("unexpected extra control reply");
		end
	endtask

	task automatic check_state(input logic [31:0] st);
		if (st == 1)
		begin
			check_val("state_listen_o", 1, st_listen);
			check_val("state_estblsh_o", 0, st_estblsh);
		end
		else if (st == 2)
			check_val("state_estblsh_o", 1, st_estblsh);
	endtask

	// Closed lasts one cycle, seen as both state outputs low
	task automatic wait_state(input logic [31:0] st);
		int n;
		bit gap;
		bit hit;
		n = 0;
		gap = 0;
		hit = 0;
		while (!hit && n < TIMEOUT)
		begin
			@(negedge clk);
			n++;
			if (ctrl_start)
				fail("control reply where none was expected");
			if (!st_listen && !st_estblsh)
				gap = 1;
			hit = (st == 1) ? st_listen : (st == 2) ? st_estblsh : 1'b1;
		end
		if (!hit)
			fail("connection state never reached the expected value");
		if (st == 1 && !gap)
			fail("listen came back without passing a closed state");
		check_state(st);
	endtask

	// Act as encoder for n packets, then watch that the limit holds
	task automatic pace(input int n, input logic [31:0] plen, input logic [31:0] sq,
		input logic [31:0] ak);
		int k;
		int t;
		logic [31:0] exp_seq;
		exp_seq = sq;
		data_len = plen[15:0];
		data_rdy = 1'b1;
		for (k = 0; k < n; k++)
		begin
			t = 0;
			while (!wdat_start && t < TIMEOUT)
			begin
				@(negedge clk);
				t++;
			end
			if (!wdat_start)
			begin
				fail("data packet start never came");
				return;
			end
			@(negedge clk);
			check_val("hdr_o.flags", `TCP_FLG_PSHACK, hdr.flags.code);
			check_val("hdr_o.data_len", plen, hdr.data_len);
			check_val("hdr_o.seq_num", exp_seq, hdr.seq_num);
			check_val("hdr_o.ack_num", ak, hdr.ack_num);
			check_val("hdr_o.head_len", 5, hdr.head_len);
			repeat (2) @(negedge clk);
			wdat_stop = 1'b1;
			@(negedge clk);
			wdat_stop = 1'b0;
			exp_seq = exp_seq + plen;
		end
		repeat (40)
		begin
			@(negedge clk);
			if (wdat_start)
				fail("data packet started beyond the unacked limit");
		end
	endtask

	task automatic run_test();
		int  nb;
		bit  ok;
		int  err0;
		err0 = errors;
		tests++;
		case (op)
			0:
			begin
				nb = busy;
				if (busy == 32'hff)
				begin
					rng = xorshift(rng);
					nb = (rng % 24) + 1;
				end
				trnsmt_busy = (nb > 0);
				send_seg();
				repeat (nb)
				begin
					@(negedge clk);
					if (ctrl_start)
						fail("control reply while the transmitter was busy");
				end
				trnsmt_busy = 1'b0;
				wait_reply(ok);
				if (ok)
				begin
					check_val("hdr_o.flags", eflg, hdr.flags.code);
					check_val("hdr_o.seq_num", eseq, hdr.seq_num);
					check_val("hdr_o.ack_num", eack, hdr.ack_num);
					check_val("hdr_o.data_len", elen, hdr.data_len);
					check_val("hdr_o.dst_port", eport, hdr.dst_port);
					check_val("hdr_o.head_len", 5, hdr.head_len);
					check_val("tcp_source_port_o", 16'd63256, src_port);
				end
				check_quiet(8);
				check_state(estate);
			end
			1:
			begin
				send_seg();
				wait_state(estate);
			end
			2:
				pace(busy, elen, eseq, eack);
			3:
			begin
				send_seg();
				pace(busy, elen, eseq, eack);
				data_rdy = 1'b0;
			end
			default:
				fail("unknown operation in the data file");
		endcase
		$display("test %0d op %0d: %s", tests, op, (errors == err0) ? "ok" : "failed");
	endtask

	initial
	begin
		int    fd;
		int    n;
		string line;
		rst_n       = 1'b0;
		seg_valid   = 1'b0;
		seg         = '0;
		data_rdy    = 1'b0;
		data_len    = '0;
		trnsmt_busy = 1'b0;
		wdat_stop   = 1'b0;
		rng         = 32'd60178;
		errors      = 0;
		checks      = 0;
		tests       = 0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		check_state(1);

		fd = $fopen("sim/tcp_testdata.txt", "r");
		if (fd == 0)
			fail("could not open the test data file");
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				n = $fgets(line, fd);
				if (n > 0 && line.len() > 0 && line[0] != "#")
				begin
					n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
						op, port, flg, seq, ack, len, win, busy,
						eflg, eseq, eack, elen, eport, estate);
					if (n == 14)
						run_test();
				end
			end
			$fclose(fd);
		end

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0 && tests > 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* sim/tcp_testdata.txt */
# op port flags seq ack len window busy | exp: flags seq ack len dst_port state
# op 0 reply, 1 no reply, 2 pacing, 3 segment then pacing; busy ff is random, state 1 listen 2 est
0 04d2 10 00000100 00005000 0000 ea60 00 14 00005000 00000100 0000 0000 1
0 1f90 02 00001000 00000000 0000 ea60 00 12 00000000 00001001 0000 1f90 0
1 1f90 10 00001001 00000001 0000 ea60 00 00 00000000 00000000 0000 0000 2
0 1f90 10 00001001 00000001 0040 ea60 00 10 00000001 00001041 0000 1f90 2
0 1f90 10 00001041 00000001 0080 ea60 ff 10 00000001 000010c1 0000 1f90 2
0 1f90 10 000010c1 00000001 0020 ea60 ff 10 00000001 000010e1 0000 1f90 2
0 1f90 10 000010e1 00000001 0100 ea60 ff 10 00000001 000011e1 0000 1f90 2
2 0000 00 00000000 00000000 0000 0000 10 18 00000001 000011e1 0200 1f90 2
3 1f90 10 000011e1 00002001 0000 ea60 10 18 00002001 000011e1 0200 1f90 2
0 1f90 11 000011e1 00004001 0000 ea60 00 11 00004001 000011e2 0000 1f90 0
1 1f90 10 000011e2 00004002 0000 ea60 00 00 00000000 00000000 0000 0000 1
0 2328 02 00007000 00000000 0000 ea60 00 12 00000000 00007001 0000 2328 0
1 2328 10 00007001 00000001 0000 ea60 00 00 00000000 00000000 0000 0000 2
1 2328 04 00007001 00000001 0000 ea60 00 00 00000000 00000000 0000 0000 1
0 0037 10 00000300 00000900 0000 ea60 00 14 00000900 00000300 0000 2328 1

/* vlog.f */
+incdir+src
src/tcp_ctrl_pkg.sv
src/tcp_seg_sampler.sv
src/tcp_event_fifo.sv
src/tcp_conn_engine.sv
src/tcp_data_pacer.sv
src/tcp_controller_top.sv
sim/tcp_controller_tb.sv
